/* usbEp_macros.svh */
`ifndef USB_EP_MACROS_SVH
`define USB_EP_MACROS_SVH

// Address width of each transaction FIFO
// 5 bits gives 32 bytes, of which 31 can hold data
`define EP_ADDR_WID 5

// Every payload on both sides is one byte
`define EP_DATA_WID 8

// EP0 control, EP1 bulk and EP2 isochronous
`define EP_COUNT 3

// Endpoint numbers on the token side
// The value 3 does not exist and is answered with a STALL
`define EP_NUM_WID 2

`endif

/* usbEpPkg.sv */
`include "usbEp_macros.svh"

package usbEpPkg;

    // Transfer type of a non-control endpoint
    typedef enum logic [1:0] {
        NONE,
        BULK,
        INTERRUPT,
        ISOCHRONOUS
    } EpType;

    // A control endpoint overrides epType and always stalls in this direction
    typedef struct packed {
        logic isControlEp;
        EpType epType;
    } EndpointConfig;

    // Only the upper two PID bits are carried, the encoder adds the rest
    // NAK shares its code with DATA1 and is told apart by the handshake flag
    localparam logic [1:0] PID_DATA0 = 2'b00;
    localparam logic [1:0] PID_DATA1 = 2'b10;
    localparam logic [1:0] RES_NAK = 2'b10;
    localparam logic [1:0] RES_STALL = 2'b11;

    // Response that an endpoint gives to an IN token
    typedef struct packed {
        logic valid;
        logic isHandshake;
        logic [1:0] pid;
    } EpResp;

    // Device logic writing a packet into an endpoint
    typedef struct packed {
        logic dataValid;
        logic [`EP_DATA_WID-1:0] data;
        logic transDone;
        logic transSuccess;
    } FillReq;

    // Host side reading a packet out of an endpoint
    typedef struct packed {
        logic popData;
        logic transDone;
        logic transSuccess;
    } PopReq;

    // Byte at the current read position and its flags
    typedef struct packed {
        logic dataAvailable;
        logic isLast;
        logic [`EP_DATA_WID-1:0] data;
    } PopData;

endpackage

/* transFifo.sv */
`timescale 1ns/1ns

`include "usbEp_macros.svh"

module transFifo (
    input logic clk12_i,
    input logic arstN_i,

    input usbEpPkg::FillReq fill_i,
    output logic full_o,

    input usbEpPkg::PopReq pop_i,
    output usbEpPkg::PopData popData_o
);

    localparam int DEPTH = 2 ** `EP_ADDR_WID;

    // Packet storage
    logic [`EP_DATA_WID-1:0] mem [DEPTH];

    // Tentative pointers move with every byte
    // Committed pointers only move when a transaction ends successfully
    logic [`EP_ADDR_WID-1:0] wrTent;
    logic [`EP_ADDR_WID-1:0] wrCommit;
    logic [`EP_ADDR_WID-1:0] rdTent;
    logic [`EP_ADDR_WID-1:0] rdCommit;

    // Pointer values one step ahead, wrapping at the FIFO depth
    logic [`EP_ADDR_WID-1:0] wrTentInc;
    logic [`EP_ADDR_WID-1:0] rdTentInc;

    // Pointer values including the byte moved in this cycle
    logic [`EP_ADDR_WID-1:0] wrTentNext;
    logic [`EP_ADDR_WID-1:0] rdTentNext;

    logic writeEn;
    logic readEn;

    assign wrTentInc = wrTent + 1'b1;
    assign rdTentInc = rdTent + 1'b1;

    // The writer must not overtake committed bytes that the host may still resend
    assign full_o = wrTentInc == rdCommit;

    // A byte is only written while there is room for it
    assign writeEn = fill_i.dataValid && !full_o;

    // The reader cannot move past the last committed byte
    assign readEn = pop_i.popData && (rdTent != wrCommit);

    assign wrTentNext = writeEn ? wrTentInc : wrTent;
    assign rdTentNext = readEn ? rdTentInc : rdTent;

    // Committed data exists that the host has not acknowledged yet
    assign popData_o.dataAvailable = wrCommit != rdCommit;

    // The next pop would reach the end of the committed data
    assign popData_o.isLast = rdTentInc == wrCommit;

    // Read is combinational so one byte can be popped every cycle
    assign popData_o.data = mem[rdTent];

    always_ff @(posedge clk12_i) begin
        if (writeEn) begin
            mem[wrTent] <= fill_i.data;
        end
    end

    // Fill side, the packet is either kept or thrown away at its end
    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            wrTent <= '0;
            wrCommit <= '0;
        end else if (fill_i.transDone) begin
            if (fill_i.transSuccess) begin
                wrTent <= wrTentNext;
                wrCommit <= wrTentNext;
            end else begin
                // Drop every byte written since the last commit
                wrTent <= wrCommit;
            end
        end else begin
            wrTent <= wrTentNext;
        end
    end

    // Pop side, an acknowledged packet is released, otherwise it is read again
    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            rdTent <= '0;
            rdCommit <= '0;
        end else if (pop_i.transDone) begin
            if (pop_i.transSuccess) begin
                rdTent <= rdTentNext;
                rdCommit <= rdTentNext;
            end else begin
                // Host did not acknowledge, so rewind to the packet start
                rdTent <= rdCommit;
            end
        end else begin
            rdTent <= rdTentNext;
        end
    end

endmodule

/* usbEndpointIn.sv */
`timescale 1ns/1ns

module usbEndpointIn #(
    parameter usbEpPkg::EndpointConfig EP_CONF = '{isControlEp: 1'b0, epType: usbEpPkg::BULK}
) (
    input logic clk12_i,
    input logic arstN_i,

    input logic gotToken_i,
    input logic resetDataToggle_i,

    // Device logic side
    input usbEpPkg::FillReq fill_i,
    output logic full_o,

    // Host side
    input usbEpPkg::PopReq pop_i,
    output usbEpPkg::PopData popData_o,

    output usbEpPkg::EpResp resp_o
);

    // Response decided at the token edge, registered below
    logic respHandshakeNext;
    logic [1:0] respPidNext;

    usbEpPkg::EpResp respQ;

    generate
        if (!EP_CONF.isControlEp && EP_CONF.epType != usbEpPkg::NONE) begin : genDataEp

            logic dataToggle;

            if (EP_CONF.epType == usbEpPkg::ISOCHRONOUS) begin : genIsoToggle
                // Isochronous packets carry no sequence, always DATA0
                assign dataToggle = 1'b0;
            end else begin : genSeqToggle
                // Bulk and interrupt start at DATA0 and flip on each acknowledged packet
                always_ff @(posedge clk12_i or negedge arstN_i) begin
                    if (!arstN_i) begin
                        dataToggle <= 1'b0;
                    end else if (resetDataToggle_i) begin
                        dataToggle <= 1'b0;
                    end else if (pop_i.transDone && pop_i.transSuccess) begin
                        dataToggle <= !dataToggle;
                    end
                end
            end

            transFifo fifoIn (
                .clk12_i(clk12_i),
                .arstN_i(arstN_i),
                .fill_i(fill_i),
                .full_o(full_o),
                .pop_i(pop_i),
                .popData_o(popData_o)
            );

            // Nothing committed means the host gets a NAK handshake
            assign respHandshakeNext = !popData_o.dataAvailable;

            // Otherwise the toggle picks DATA0 or DATA1
            assign respPidNext = !popData_o.dataAvailable ? usbEpPkg::RES_NAK :
                (dataToggle ? usbEpPkg::PID_DATA1 : usbEpPkg::PID_DATA0);

        end else begin : genStallEp

            // Control or unused endpoint, every IN token is stalled
            assign respHandshakeNext = 1'b1;
            assign respPidNext = usbEpPkg::RES_STALL;

            // No storage behind this endpoint
            assign full_o = 1'b0;
            assign popData_o = '0;

        end
    endgenerate

    // Valid pulses one cycle after the token
    // the PID is held until the next token
    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            respQ <= '0;
        end else begin
            respQ.valid <= gotToken_i;
            if (gotToken_i) begin
                respQ.isHandshake <= respHandshakeNext;
                respQ.pid <= respPidNext;
            end
        end
    end

    assign resp_o = respQ;

endmodule

/* epRespSelect.sv */
`timescale 1ns/1ns

`include "usbEp_macros.svh"

module epRespSelect (
    input logic clk12_i,
    input logic arstN_i,

    // Host side
    input logic tokenStrobe_i,
    input logic [`EP_NUM_WID-1:0] tokenEp_i,
    input usbEpPkg::PopReq pop_i,
    output usbEpPkg::PopData popData_o,
    output usbEpPkg::EpResp resp_o,

    // Endpoint side
    output logic [`EP_COUNT-1:0] epToken_o,
    output usbEpPkg::PopReq [`EP_COUNT-1:0] epPop_o,
    input usbEpPkg::PopData [`EP_COUNT-1:0] epPopData_i,
    input usbEpPkg::EpResp [`EP_COUNT-1:0] epResp_i
);

    // Endpoint addressed by the last token
    logic [`EP_NUM_WID-1:0] selEp;

    // Token delay used for the STALL of a missing endpoint
    logic tokenQ;

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            selEp <= '0;
            tokenQ <= 1'b0;
        end else begin
            tokenQ <= tokenStrobe_i;
            if (tokenStrobe_i) begin
                selEp <= tokenEp_i;
            end
        end
    end

    // One-hot token strobe, an unknown number reaches no endpoint
    always_comb begin
        for (int i = 0; i < `EP_COUNT; i++) begin
            epToken_o[i] = tokenStrobe_i && (tokenEp_i == i);
        end
    end

    // Pop strobes only reach the selected endpoint, its data and response come back
    always_comb begin
        popData_o = '0;
        // Endpoint number not present, so answer with our own STALL
        resp_o.valid = tokenQ;
        resp_o.isHandshake = 1'b1;
        resp_o.pid = usbEpPkg::RES_STALL;
        for (int i = 0; i < `EP_COUNT; i++) begin
            epPop_o[i] = (selEp == i) ? pop_i : '0;
            if (selEp == i) begin
                popData_o = epPopData_i[i];
                resp_o = epResp_i[i];
            end
        end
    end

endmodule

/* usbEpSubsystem.sv */
`timescale 1ns/1ns

`include "usbEp_macros.svh"

module usbEpSubsystem (
    input logic clk12_i,
    input logic arstN_i,

    // Token decoded by the SIE
    input logic tokenStrobe_i,
    input logic [`EP_NUM_WID-1:0] tokenEp_i,
    input logic resetDataToggle_i,

    // Device logic, one fill port per endpoint
    input usbEpPkg::FillReq [`EP_COUNT-1:0] fill_i,
    output logic [`EP_COUNT-1:0] full_o,

    // Host side, shared by all endpoints
    input usbEpPkg::PopReq pop_i,
    output usbEpPkg::PopData popData_o,
    output usbEpPkg::EpResp resp_o
);

    // EP0 is control and stalls, EP1 is bulk, EP2 is isochronous
    localparam usbEpPkg::EndpointConfig EP_CONFS [`EP_COUNT] = '{
        '{isControlEp: 1'b1, epType: usbEpPkg::NONE},
        '{isControlEp: 1'b0, epType: usbEpPkg::BULK},
        '{isControlEp: 1'b0, epType: usbEpPkg::ISOCHRONOUS}
    };

    logic [`EP_COUNT-1:0] epToken;
    usbEpPkg::PopReq [`EP_COUNT-1:0] epPop;
    usbEpPkg::PopData [`EP_COUNT-1:0] epPopData;
    usbEpPkg::EpResp [`EP_COUNT-1:0] epResp;

    generate
        for (genvar i = 0; i < `EP_COUNT; i++) begin : genEp
            usbEndpointIn #(
                .EP_CONF(EP_CONFS[i])
            ) epIn (
                .clk12_i(clk12_i),
                .arstN_i(arstN_i),
                .gotToken_i(epToken[i]),
                .resetDataToggle_i(resetDataToggle_i),
                .fill_i(fill_i[i]),
                .full_o(full_o[i]),
                .pop_i(epPop[i]),
                .popData_o(epPopData[i]),
                .resp_o(epResp[i])
            );
        end
    endgenerate

    epRespSelect respSel (
        .clk12_i(clk12_i),
        .arstN_i(arstN_i),
        .tokenStrobe_i(tokenStrobe_i),
        .tokenEp_i(tokenEp_i),
        .pop_i(pop_i),
        .popData_o(popData_o),
        .resp_o(resp_o),
        .epToken_o(epToken),
        .epPop_o(epPop),
        .epPopData_i(epPopData),
        .epResp_i(epResp)
    );

endmodule

/* usbEpTb.sv */
`timescale 1ns/1ns

`include "usbEp_macros.svh"

module usbEpTb;

    localparam int DEPTH = 2 ** `EP_ADDR_WID;

    logic clk12 = 1'b0;
    logic arstN;
    logic tokenStrobe;
    logic [`EP_NUM_WID-1:0] tokenEp;
    logic resetDataToggle;
    usbEpPkg::FillReq [`EP_COUNT-1:0] fillReq;
    logic [`EP_COUNT-1:0] full;
    usbEpPkg::PopReq popReq;
    usbEpPkg::PopData popData;
    usbEpPkg::EpResp resp;

    // Bytes committed into each endpoint that the host has not acknowledged yet
    logic [`EP_DATA_WID-1:0] model [`EP_COUNT][$];

    // Endpoint latched by the selector at the last token
    int curEp = 0;
    int seed = 32'hdeb5_2419;

    always #20 clk12 = !clk12;

    usbEpSubsystem u_dut (
        .clk12_i(clk12),
        .arstN_i(arstN),
        .tokenStrobe_i(tokenStrobe),
        .tokenEp_i(tokenEp),
        .resetDataToggle_i(resetDataToggle),
        .fill_i(fillReq),
        .full_o(full),
        .pop_i(popReq),
        .popData_o(popData),
        .resp_o(resp)
    );

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("test failed");
        $fatal(1);
    endtask

    // Streams one random byte per cycle, then commits or drops the packet
    task automatic fillPacket(input int ep, input int len, input bit commit);
        logic [`EP_DATA_WID-1:0] bytes [$];
        logic [31:0] rnd;
        for (int i = 0; i < len; i++) begin
            rnd = $random(seed);
            bytes.push_back(rnd[`EP_DATA_WID-1:0]);
            @(negedge clk12);
            checkEq(full[ep], 1'b0, "full flag during fill");
            @(posedge clk12);
            fillReq[ep] <= '{dataValid: 1'b1, data: bytes[i], transDone: 1'b0,
                             transSuccess: 1'b0};
        end
        @(posedge clk12);
        fillReq[ep] <= '{dataValid: 1'b0, data: '0, transDone: 1'b1, transSuccess: commit};
        @(posedge clk12);
        fillReq[ep] <= '0;
        // Only a committed packet becomes visible to the host
        if (commit) begin
            foreach (bytes[i]) model[ep].push_back(bytes[i]);
        end
    endtask

    // One slot is always kept free, so depth minus one bytes fill the FIFO
    task automatic testFull(input int ep);
        checkEq(model[ep].size(), 0, "endpoint empty before full test");
        for (int i = 0; i < DEPTH - 1; i++) begin
            @(posedge clk12);
            fillReq[ep] <= '{dataValid: 1'b1, data: i[`EP_DATA_WID-1:0], transDone: 1'b0,
                             transSuccess: 1'b0};
        end
        // The last byte is driven but not yet written here
        @(negedge clk12);
        checkEq(full[ep], 1'b0, "full flag one byte before full");
        @(posedge clk12);
        fillReq[ep] <= '0;
        @(negedge clk12);
        checkEq(full[ep], 1'b1, "full flag at depth minus one");
        @(posedge clk12);
        fillReq[ep] <= '{dataValid: 1'b0, data: '0, transDone: 1'b1, transSuccess: 1'b0};
        @(posedge clk12);
        fillReq[ep] <= '0;
        @(negedge clk12);
        checkEq(full[ep], 1'b0, "full flag after abort");
    endtask

    task automatic sendToken(input int ep, input logic [1:0] pid, input logic hs);
        int waitCycles;
        @(posedge clk12);
        tokenStrobe <= 1'b1;
        tokenEp <= ep[`EP_NUM_WID-1:0];
        @(posedge clk12);
        tokenStrobe <= 1'b0;
        waitCycles = 0;
        @(negedge clk12);
        while (!resp.valid && waitCycles < 10) begin
            waitCycles++;
            @(negedge clk12);
        end
        if (!resp.valid) begin
            abortRun("no response to the IN token within 10 cycles");
        end
        // The token edge was the one just before this sample
        checkEq(waitCycles, 0, "response delay after token");
        checkEq(resp.isHandshake, hs, "response handshake bit");
        checkEq(resp.pid, pid, "response PID");
        @(negedge clk12);
        checkEq(resp.valid, 1'b0, "response valid for a single cycle");
        curEp = ep;
    endtask

    // Pops every committed byte of the selected endpoint, then acks or rewinds
    task automatic popPacket(input int count, input bit ack);
        checkEq(model[curEp].size(), count, "bytes waiting in endpoint");
        for (int i = 0; i < count; i++) begin
            @(negedge clk12);
            checkEq(popData.dataAvailable, 1'b1, "data available while popping");
            checkEq(popData.data, model[curEp][i], "popped byte");
            checkEq(popData.isLast, i == count - 1, "last byte flag");
            @(posedge clk12);
            popReq <= '{popData: 1'b1, transDone: 1'b0, transSuccess: 1'b0};
            @(posedge clk12);
            popReq <= '0;
        end
        @(posedge clk12);
        popReq <= '{popData: 1'b0, transDone: 1'b1, transSuccess: ack};
        @(posedge clk12);
        popReq <= '0;
        if (ack) begin
            model[curEp].delete();
        end
        @(negedge clk12);
        checkEq(popData.dataAvailable, model[curEp].size() != 0, "data available after pop");
    endtask

    task automatic pulseToggleReset();
        @(posedge clk12);
        resetDataToggle <= 1'b1;
        @(posedge clk12);
        resetDataToggle <= 1'b0;
    endtask

    initial begin
        int fd;
        int r;
        int ep;
        int len;
        int flag;
        int pid;
        string op;
        string line;
        arstN = 1'b0;
        tokenStrobe = 1'b0;
        tokenEp = '0;
        resetDataToggle = 1'b0;
        fillReq = '0;
        popReq = '0;
        fd = $fopen("usbEpCases.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open usbEpCases.txt");
        end
        repeat (2) @(posedge clk12);
        arstN <= 1'b1;
        // Each line holds one operation and its first word says which
        while ($fscanf(fd, "%s", op) == 1) begin
            case (op)
                "#": r = $fgets(line, fd);
                "fill": begin
                    r = $fscanf(fd, "%d %d %d", ep, len, flag);
                    if (r != 3) begin
                        abortRun("fill line in cases file is missing a field");
                    end
                    fillPacket(ep, len, flag[0]);
                end
                "token": begin
                    r = $fscanf(fd, "%d %b %d", ep, pid, flag);
                    if (r != 3) begin
                        abortRun("token line in cases file is missing a field");
                    end
                    sendToken(ep, pid[1:0], flag[0]);
                end
                "pop": begin
                    r = $fscanf(fd, "%d %d", len, flag);
                    if (r != 2) begin
                        abortRun("pop line in cases file is missing a field");
                    end
                    popPacket(len, flag[0]);
                end
                "full": begin
                    r = $fscanf(fd, "%d", ep);
                    if (r != 1) begin
                        abortRun("full line in cases file is missing the endpoint");
                    end
                    testFull(ep);
                end
                "togglereset": pulseToggleReset();
                default: abortRun({"unknown operation in cases file: ", op});
            endcase
        end
        $fclose(fd);
        $display("test passed");
        $finish;
    end

endmodule

/* usbEpCases.txt */
# Lines: fill ep len commit | token ep pid handshake | pop bytes ack | full ep | togglereset
# Pid is binary: 00 DATA0, 10 DATA1 or NAK with handshake 1, 11 STALL
# Empty bulk endpoint answers NAK
token 1 10 1
# Committed packet, read without ack, resent and acknowledged
fill 1 4 1
token 1 00 0
pop 4 0
token 1 00 0
pop 4 1
token 1 10 1
fill 1 3 1
token 1 10 0
pop 3 1
# Aborted packet leaves the FIFO empty, then the full flag
fill 1 5 0
token 1 10 1
full 1
token 1 10 1
# Control endpoint and missing endpoint stall
token 0 11 1
token 3 11 1
# Isochronous endpoint stays at DATA0
fill 2 6 1
token 2 00 0
pop 6 1
fill 2 2 1
token 2 00 0
pop 2 1
token 2 10 1
# Toggle reset brings the bulk endpoint back to DATA0
fill 1 2 1
token 1 00 0
pop 2 1
fill 1 2 1
token 1 10 0
pop 2 0
togglereset
token 1 00 0
pop 2 1
token 1 10 1

/* src.f */
+incdir+.
usbEpPkg.sv
transFifo.sv
usbEndpointIn.sv
epRespSelect.sv
usbEpSubsystem.sv
usbEpTb.sv

/* Makefile */
# Verilator build and run of the USB IN endpoint testbench
VERILATOR ?= verilator
TOP ?= usbEpTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard *.sv *.svh) $(FILELIST)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

test: $(BUILD_DIR)/$(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
